// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP ?= platformer_tb
FILELIST ?= platformer.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== platformer.f ====
rtl/level_pkg.sv
rtl/player_pkg.sv
rtl/level_map.sv
rtl/coin_bank.sv
rtl/player_motion.sv
rtl/scanline_renderer.sv
rtl/platformer_top.sv
verification/tb_clock.sv
verification/platformer_tb.sv

// ==== rtl/coin_bank.sv ====
// coin_bank: remaining coin flags, clears coins the player touches and counts the score
`timescale 1ns/1ns

module coin_bank (
	input  logic                            Clk,
	input  logic                            Reset,
	input  player_pkg::player_t             player,
	output logic [level_pkg::NUM_COINS-1:0] coins_left,
	output logic [level_pkg::SCORE_W-1:0]   score
);

	logic [5:0] col_l;
	logic [5:0] col_r;
	logic [5:0] row_t;
	logic [5:0] row_b;
	logic [level_pkg::NUM_COINS-1:0] hit;

	// tiles under the four corners of the player box
	assign col_r = 6'(player.world_x >> level_pkg::TILE_SHIFT);
	assign col_l = 6'((player.world_x - 10'(player_pkg::PLAYER_W - 1)) >> level_pkg::TILE_SHIFT);
	assign row_b = 6'(player.y >> level_pkg::TILE_SHIFT);
	assign row_t = 6'((player.y - 10'(player_pkg::PLAYER_H - 1)) >> level_pkg::TILE_SHIFT);

	always_comb begin
		for (int i = 0; i < level_pkg::NUM_COINS; i++) begin
			hit[i] = (row_t == 6'(level_pkg::COIN_CELLS[i].row) ||
					row_b == 6'(level_pkg::COIN_CELLS[i].row)) &&
				(col_l == level_pkg::COIN_CELLS[i].col ||
					col_r == level_pkg::COIN_CELLS[i].col);
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			coins_left <= '1;
		end else begin
			coins_left <= coins_left & ~hit;
		end
	end

	// one point per collected coin
	always_comb begin
		score = '0;
		for (int i = 0; i < level_pkg::NUM_COINS; i++) begin
			if (!coins_left[i]) begin
				score = score + 1'b1;
			end
		end
	end

	// a collected coin stays gone until the next reset
	property coin_stays_cleared;
		@(posedge Clk) disable iff (Reset)
		(coins_left & ~$past(coins_left)) == '0;
	endproperty
	assert property (coin_stays_cleared);

endmodule

// ==== rtl/level_map.sv ====
// level_map: tile kind at three world coordinates with live coins overlaid on the layout
`timescale 1ns/1ns

module level_map (
	input  level_pkg::tile_probe_t          probe_a,
	input  level_pkg::tile_probe_t          probe_b,
	input  level_pkg::tile_probe_t          pix_world,
	input  logic [level_pkg::NUM_COINS-1:0] coins_left,
	output level_pkg::tile_kind_e           probe_a_kind,
	output level_pkg::tile_kind_e           probe_b_kind,
	output level_pkg::tile_kind_e           pix_kind
);

	function automatic level_pkg::tile_kind_e kind_at(
		input level_pkg::tile_probe_t p,
		input logic [level_pkg::NUM_COINS-1:0] live
	);
		logic [5:0] col;
		logic [5:0] row;
		level_pkg::tile_kind_e kind;
		col = 6'(p.x >> level_pkg::TILE_SHIFT);
		row = 6'(p.y >> level_pkg::TILE_SHIFT);
		kind = level_pkg::TILE_SKY;
		// floor rows, and anything below the map
		if (row >= 6'(level_pkg::FLOOR_ROW)) begin
			kind = level_pkg::TILE_FLOOR;
		end else if (col >= 6'(level_pkg::MAP_COLS)) begin
			// off the right end acts as a wall
			kind = level_pkg::TILE_BLOCK;
		end else if (level_pkg::BLOCK_MAP[row[3:0]][col]) begin
			kind = level_pkg::TILE_BLOCK;
		end else begin
			for (int i = 0; i < level_pkg::NUM_COINS; i++) begin
				if (live[i] && row[3:0] == level_pkg::COIN_CELLS[i].row &&
						col == level_pkg::COIN_CELLS[i].col) begin
					kind = level_pkg::TILE_COIN;
				end
			end
		end
		return kind;
	endfunction

	// player probes
	assign probe_a_kind = kind_at(probe_a, coins_left);
	assign probe_b_kind = kind_at(probe_b, coins_left);

	// renderer lookup
	assign pix_kind = kind_at(pix_world, coins_left);

endmodule

// ==== rtl/level_pkg.sv ====
// level_pkg: tile grid, level layout, coin cells and colours of the platformer world
package level_pkg;

	// ------------------------------------------------------------
	// world geometry
	// ------------------------------------------------------------
	localparam int TILE_SHIFT = 5;
	localparam int MAP_COLS = 60;
	localparam int MAP_ROWS = 15;
	localparam int FLOOR_ROW = 11;

	typedef logic [9:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} tile_probe_t;

	typedef enum logic [1:0] {
		TILE_SKY,
		TILE_FLOOR,
		TILE_BLOCK,
		TILE_COIN
	} tile_kind_e;

	// mask with columns lo..hi set
	function automatic logic [MAP_COLS-1:0] col_span(input int lo, input int hi);
		logic [MAP_COLS-1:0] mask;
		mask = '0;
		for (int c = lo; c <= hi; c++) begin
			mask[c] = 1'b1;
		end
		return mask;
	endfunction

	// ------------------------------------------------------------
	// level layout, one row per entry, bit c set for a block at column c
	// ------------------------------------------------------------
	localparam logic [0:MAP_ROWS-1][MAP_COLS-1:0] BLOCK_MAP = {
		{6{{MAP_COLS{1'b0}}}},
		col_span(32, 34),
		col_span(28, 28) | col_span(37, 37) | col_span(56, 56),
		col_span(19, 20) | col_span(27, 28) | col_span(37, 37) | col_span(56, 56),
		col_span(15, 16) | col_span(26, 28) | col_span(47, 52),
		col_span(14, 17) | col_span(25, 28) | col_span(46, 53),
		{4{{MAP_COLS{1'b0}}}}
	};

	// coins sit on the ground row so walking reaches them
	localparam int NUM_COINS = 3;
	localparam int SCORE_W = $clog2(NUM_COINS + 1);

	typedef struct packed {
		logic [3:0] row;
		logic [5:0] col;
	} cell_t;

	localparam cell_t [NUM_COINS-1:0] COIN_CELLS = {
		cell_t'{row: 4'd10, col: 6'd10},
		cell_t'{row: 4'd10, col: 6'd5},
		cell_t'{row: 4'd10, col: 6'd3}
	};

	// ------------------------------------------------------------
	// colours and pixel stream
	// ------------------------------------------------------------
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	localparam rgb_t COLOR_SKY = 24'h6185F8;
	localparam rgb_t COLOR_BLOCK = 24'h833D00;
	localparam rgb_t COLOR_FLOOR = 24'hA55C39;
	localparam rgb_t COLOR_COIN = 24'hFFC107;
	localparam rgb_t COLOR_PLAYER = 24'hF83800;
	localparam rgb_t COLOR_BLANK = 24'h000000;

	typedef struct packed {
		coord_t draw_x;
		coord_t draw_y;
		logic display_en;
	} pixel_t;

endpackage

// ==== rtl/platformer_top.sv ====
// platformer_top: side-scroller core with map, coins, player motion and renderer
`timescale 1ns/1ns

module platformer_top (
	input  logic                          Clk,
	input  logic                          Reset,
	input  logic                          frame_tick,
	input  logic [7:0]                    keycode,
	input  level_pkg::pixel_t             pixel,
	output level_pkg::rgb_t               rgb,
	output player_pkg::player_t           player,
	output logic [level_pkg::SCORE_W-1:0] score
);

	level_pkg::tile_probe_t probe_a;
	level_pkg::tile_probe_t probe_b;
	level_pkg::tile_probe_t pix_world;
	level_pkg::tile_kind_e probe_a_kind;
	level_pkg::tile_kind_e probe_b_kind;
	level_pkg::tile_kind_e pix_kind;
	logic [level_pkg::NUM_COINS-1:0] coins_left;

	// shared tile lookup for motion and drawing
	level_map level_map_i (
		.probe_a(probe_a),
		.probe_b(probe_b),
		.pix_world(pix_world),
		.coins_left(coins_left),
		.probe_a_kind(probe_a_kind),
		.probe_b_kind(probe_b_kind),
		.pix_kind(pix_kind)
	);

	coin_bank coin_bank_i (
		.Clk(Clk),
		.Reset(Reset),
		.player(player),
		.coins_left(coins_left),
		.score(score)
	);

	player_motion player_motion_i (
		.Clk(Clk),
		.Reset(Reset),
		.frame_tick(frame_tick),
		.keycode(keycode),
		.probe_a(probe_a),
		.probe_b(probe_b),
		.probe_a_kind(probe_a_kind),
		.probe_b_kind(probe_b_kind),
		.player(player)
	);

	scanline_renderer scanline_renderer_i (
		.Clk(Clk),
		.Reset(Reset),
		.pixel(pixel),
		.player(player),
		.pix_world(pix_world),
		.pix_kind(pix_kind),
		.rgb(rgb)
	);

endmodule

// ==== rtl/player_motion.sv ====
// player_motion: per-frame sequencer for gravity, walking, collision and camera scroll
`timescale 1ns/1ns

module player_motion (
	input  logic                   Clk,
	input  logic                   Reset,
	input  logic                   frame_tick,
	input  logic [7:0]             keycode,
	output level_pkg::tile_probe_t probe_a,
	output level_pkg::tile_probe_t probe_b,
	input  level_pkg::tile_kind_e  probe_a_kind,
	input  level_pkg::tile_kind_e  probe_b_kind,
	output player_pkg::player_t    player
);

	typedef enum logic [1:0] {
		IDLE,
		FALL_PROBE,
		SIDE_PROBE,
		COMMIT
	} state_e;

	// signed, wide enough for camera range and negative edges
	typedef logic signed [11:0] wide_t;

	state_e state;
	logic [2:0] fall;
	logic [2:0] fall_try;
	player_pkg::key_e key;
	logic probe_hit;
	level_pkg::coord_t y_try;
	level_pkg::coord_t y_snap;
	level_pkg::coord_t y_new;
	level_pkg::coord_t right_lead;
	level_pkg::coord_t left_edge;
	level_pkg::coord_t side_x;
	level_pkg::coord_t x_try;
	level_pkg::coord_t x_snap;
	level_pkg::coord_t x_new;
	wide_t left_lead;
	wide_t screen_new;
	wide_t cam_try;

	always_comb begin
		if (keycode == player_pkg::KEY_LEFT) begin
			key = player_pkg::KEY_LEFT;
		end else if (keycode == player_pkg::KEY_RIGHT) begin
			key = player_pkg::KEY_RIGHT;
		end else begin
			key = player_pkg::KEY_NONE;
		end
	end

	assign probe_hit = (probe_a_kind inside {level_pkg::TILE_FLOOR, level_pkg::TILE_BLOCK}) ||
		(probe_b_kind inside {level_pkg::TILE_FLOOR, level_pkg::TILE_BLOCK});

	// ------------------------------------------------------------
	// fall step, capped speed and snap onto the tile row below
	// ------------------------------------------------------------
	assign fall_try = (fall >= 3'(player_pkg::TERMINAL_FALL)) ?
		3'(player_pkg::TERMINAL_FALL) : fall + 3'd1;
	assign y_try = player.y + {7'd0, fall_try};
	assign y_snap = ((y_try >> level_pkg::TILE_SHIFT) << level_pkg::TILE_SHIFT) - 10'd1;

	// ------------------------------------------------------------
	// walk step, leading edge and snap flush against a wall
	// ------------------------------------------------------------
	assign right_lead = player.world_x + 10'(player_pkg::WALK_STEP);
	assign left_lead = wide_t'({2'b00, player.world_x}) -
		wide_t'(player_pkg::PLAYER_W - 1 + player_pkg::WALK_STEP);
	// left edge never goes past world x 0
	assign left_edge = (left_lead < 0) ? '0 : level_pkg::coord_t'(left_lead);
	assign side_x = (key == player_pkg::KEY_RIGHT) ? right_lead : left_edge;

	always_comb begin
		x_try = player.world_x;
		x_snap = player.world_x;
		if (key == player_pkg::KEY_RIGHT) begin
			x_try = right_lead;
			x_snap = ((right_lead >> level_pkg::TILE_SHIFT) << level_pkg::TILE_SHIFT) - 10'd1;
		end else if (key == player_pkg::KEY_LEFT) begin
			x_try = left_edge + 10'(player_pkg::PLAYER_W - 1);
			x_snap = (((left_edge >> level_pkg::TILE_SHIFT) + 10'd1) << level_pkg::TILE_SHIFT) +
				10'(player_pkg::PLAYER_W - 1);
		end
	end

	// bottom corners while falling, leading edge top and bottom while walking
	always_comb begin
		probe_a = '{x: player.world_x - 10'(player_pkg::PLAYER_W - 1), y: y_try};
		probe_b = '{x: player.world_x, y: y_try};
		if (state == SIDE_PROBE) begin
			probe_a = '{x: side_x, y: y_new - 10'(player_pkg::PLAYER_H - 1)};
			probe_b = '{x: side_x, y: y_new};
		end
	end

	// camera soaks up motion past the scroll band
	always_comb begin
		screen_new = wide_t'({2'b00, x_new}) - wide_t'({2'b00, player.cam_x});
		cam_try = wide_t'({2'b00, player.cam_x});
		if (screen_new > wide_t'(player_pkg::SCROLL_MAX_X)) begin
			cam_try = cam_try + (screen_new - wide_t'(player_pkg::SCROLL_MAX_X));
		end else if (screen_new - wide_t'(player_pkg::PLAYER_W - 1) <
				wide_t'(player_pkg::SCROLL_MIN_X)) begin
			cam_try = cam_try - (wide_t'(player_pkg::SCROLL_MIN_X) -
				(screen_new - wide_t'(player_pkg::PLAYER_W - 1)));
		end
		if (cam_try < 0) begin
			cam_try = '0;
		end else if (cam_try > wide_t'(player_pkg::CAM_MAX)) begin
			cam_try = wide_t'(player_pkg::CAM_MAX);
		end
	end

	// ------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= IDLE;
			fall <= '0;
			player.world_x <= 10'(player_pkg::START_X);
			player.y <= 10'(player_pkg::START_Y);
			player.cam_x <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (frame_tick) begin
						state <= FALL_PROBE;
					end
				end
				FALL_PROBE: begin
					fall <= probe_hit ? 3'd0 : fall_try;
					state <= SIDE_PROBE;
				end
				SIDE_PROBE: begin
					state <= COMMIT;
				end
				default: begin
					player.world_x <= x_new;
					player.y <= y_new;
					player.cam_x <= level_pkg::coord_t'(cam_try);
					state <= IDLE;
				end
			endcase
		end
	end

	// staged position for the commit
	always_ff @(posedge Clk) begin
		if (state == FALL_PROBE) begin
			y_new <= probe_hit ? y_snap : y_try;
		end
		if (state == SIDE_PROBE) begin
			x_new <= probe_hit ? x_snap : x_try;
		end
	end

	// speed climbs at most one step per frame and never passes terminal
	property fall_speed_bounded;
		@(posedge Clk) disable iff (Reset)
		(fall <= 3'(player_pkg::TERMINAL_FALL)) &&
			(fall == 3'd0 || {1'b0, fall} <= {1'b0, $past(fall)} + 4'd1);
	endproperty
	assert property (fall_speed_bounded);

	// left side of the box stays inside the world
	property left_edge_on_world;
		@(posedge Clk) disable iff (Reset)
		player.world_x >= 10'(player_pkg::PLAYER_W - 1);
	endproperty
	assert property (left_edge_on_world);

endmodule

// ==== rtl/player_pkg.sv ====
// player_pkg: player box, motion limits, scroll bounds, key codes and player state
package player_pkg;

	// box size in pixels, position is the bottom-right corner
	localparam int PLAYER_W = 26;
	localparam int PLAYER_H = 32;

	localparam int START_X = 228;
	localparam int START_Y = 33;

	// ------------------------------------------------------------
	// motion limits, pixels per frame
	// ------------------------------------------------------------
	localparam int TERMINAL_FALL = 6;
	localparam int WALK_STEP = 4;

	// camera follows when the player leaves this screen band
	localparam int SCROLL_MAX_X = 384;
	localparam int SCROLL_MIN_X = 190;
	localparam int SCREEN_W = 640;
	localparam int CAM_MAX = (level_pkg::MAP_COLS << level_pkg::TILE_SHIFT) - SCREEN_W;

	// keyboard usage codes, anything else means no key
	typedef enum logic [7:0] {
		KEY_NONE = 8'h00,
		KEY_LEFT = 8'h04,
		KEY_RIGHT = 8'h07
	} key_e;

	typedef struct packed {
		level_pkg::coord_t world_x;
		level_pkg::coord_t y;
		level_pkg::coord_t cam_x;
	} player_t;

endpackage

// ==== rtl/scanline_renderer.sv ====
// scanline_renderer: registered colour per screen pixel from player box and tile kind
`timescale 1ns/1ns

module scanline_renderer (
	input  logic                   Clk,
	input  logic                   Reset,
	input  level_pkg::pixel_t      pixel,
	input  player_pkg::player_t    player,
	output level_pkg::tile_probe_t pix_world,
	input  level_pkg::tile_kind_e  pix_kind,
	output level_pkg::rgb_t        rgb
);

	level_pkg::coord_t screen_right;
	logic in_box_x;
	logic in_box_y;
	level_pkg::rgb_t tile_color;

	// camera offset applies to x only
	assign pix_world = '{x: pixel.draw_x + player.cam_x, y: pixel.draw_y};

	// player box on screen, compared without going below zero
	assign screen_right = player.world_x - player.cam_x;
	assign in_box_x = (pixel.draw_x <= screen_right) &&
		({1'b0, pixel.draw_x} + 11'(player_pkg::PLAYER_W - 1) >= {1'b0, screen_right});
	assign in_box_y = (pixel.draw_y <= player.y) &&
		({1'b0, pixel.draw_y} + 11'(player_pkg::PLAYER_H - 1) >= {1'b0, player.y});

	always_comb begin
		case (pix_kind)
			level_pkg::TILE_FLOOR: tile_color = level_pkg::COLOR_FLOOR;
			level_pkg::TILE_BLOCK: tile_color = level_pkg::COLOR_BLOCK;
			level_pkg::TILE_COIN: tile_color = level_pkg::COLOR_COIN;
			default: tile_color = level_pkg::COLOR_SKY;
		endcase
	end

	// ------------------------------------------------------------
	// output register, blanking first, then player, then tile
	// ------------------------------------------------------------
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			rgb <= level_pkg::COLOR_BLANK;
		end else if (!pixel.display_en) begin
			rgb <= level_pkg::COLOR_BLANK;
		end else if (in_box_x && in_box_y) begin
			rgb <= level_pkg::COLOR_PLAYER;
		end else begin
			rgb <= tile_color;
		end
	end

endmodule

// ==== verification/platformer_tb.sv ====
// platformer_tb: directed tests of the platformer core against a frame-level motion model
`timescale 1ns/1ns

module platformer_tb;

	localparam int CLK_PERIOD_NS = 100;
	localparam int FRAME_CYCLES = 16;
	localparam int TILE = 1 << level_pkg::TILE_SHIFT;
	localparam int FLOOR_TOP = 11;
	localparam int COIN_ROW = 10;
	// frames issued by all tests together, run time with a fourfold margin
	localparam int FRAMES_USED = 68 + 120 + 196 + 120;
	localparam longint WATCHDOG_NS = 64'(FRAMES_USED) * FRAME_CYCLES * CLK_PERIOD_NS * 4;

	logic Clk;
	logic Reset;
	logic reset_req;
	logic frame_tick;
	logic [7:0] keycode;
	level_pkg::pixel_t pixel;
	level_pkg::rgb_t rgb;
	player_pkg::player_t player;
	logic [level_pkg::SCORE_W-1:0] score;

	int errors;
	int checks;

	// model state
	int m_x;
	int m_y;
	int m_cam;
	int m_fall;
	bit [2:0] m_coins;
	int coin_col [3] = '{3, 5, 10};

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) tb_clock_i (
		.reset_req(reset_req),
		.Clk(Clk),
		.Reset(Reset)
	);

	platformer_top dut_i (
		.Clk(Clk),
		.Reset(Reset),
		.frame_tick(frame_tick),
		.keycode(keycode),
		.pixel(pixel),
		.rgb(rgb),
		.player(player),
		.score(score)
	);

	// ------------------------------------------------------------
	// reference model of the level and the motion rules
	// ------------------------------------------------------------
	function automatic bit in_span(input int col, input int lo, input int hi);
		return col >= lo && col <= hi;
	endfunction

	function automatic bit block_at(input int row, input int col);
		case (row)
			10: return in_span(col, 14, 17) || in_span(col, 25, 28) || in_span(col, 46, 53);
			9: return in_span(col, 15, 16) || in_span(col, 26, 28) || in_span(col, 47, 52);
			8: return in_span(col, 19, 20) || in_span(col, 27, 28) || col == 37 || col == 56;
			7: return col == 28 || col == 37 || col == 56;
			6: return in_span(col, 32, 34);
			default: return 1'b0;
		endcase
	endfunction

	// floor and blocks stop the player, coins do not
	function automatic bit solid_at(input int x, input int y);
		int row;
		int col;
		row = y / TILE;
		col = x / TILE;
		if (row >= FLOOR_TOP || col >= level_pkg::MAP_COLS) begin
			return 1'b1;
		end
		return block_at(row, col);
	endfunction

	function automatic int model_score();
		int n;
		n = 0;
		for (int i = 0; i < 3; i++) begin
			if (!m_coins[i]) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic model_reset();
		m_x = player_pkg::START_X;
		m_y = player_pkg::START_Y;
		m_cam = 0;
		m_fall = 0;
		m_coins = 3'b111;
	endtask

	task automatic model_frame(input logic [7:0] key);
		int fall_try;
		int y_try;
		int y_new;
		int lead;
		int x_new;
		int screen;
		int cam;
		int i;
		// gravity on the two bottom corners
		fall_try = (m_fall >= player_pkg::TERMINAL_FALL) ? player_pkg::TERMINAL_FALL : m_fall + 1;
		y_try = m_y + fall_try;
		if (solid_at(m_x - (player_pkg::PLAYER_W - 1), y_try) || solid_at(m_x, y_try)) begin
			y_new = (y_try / TILE) * TILE - 1;
			m_fall = 0;
		end else begin
			y_new = y_try;
			m_fall = fall_try;
		end
		// walking on the leading edge, top and bottom rows
		x_new = m_x;
		if (key == player_pkg::KEY_RIGHT) begin
			lead = m_x + player_pkg::WALK_STEP;
			if (solid_at(lead, y_new - (player_pkg::PLAYER_H - 1)) || solid_at(lead, y_new)) begin
				x_new = (lead / TILE) * TILE - 1;
			end else begin
				x_new = lead;
			end
		end else if (key == player_pkg::KEY_LEFT) begin
			lead = m_x - (player_pkg::PLAYER_W - 1) - player_pkg::WALK_STEP;
			if (lead < 0) begin
				lead = 0;
			end
			if (solid_at(lead, y_new - (player_pkg::PLAYER_H - 1)) || solid_at(lead, y_new)) begin
				x_new = (lead / TILE + 1) * TILE + player_pkg::PLAYER_W - 1;
			end else begin
				x_new = lead + player_pkg::PLAYER_W - 1;
			end
		end
		// camera keeps the player inside the scroll band
		screen = x_new - m_cam;
		cam = m_cam;
		if (screen > player_pkg::SCROLL_MAX_X) begin
			cam = m_cam + screen - player_pkg::SCROLL_MAX_X;
		end else if (screen - (player_pkg::PLAYER_W - 1) < player_pkg::SCROLL_MIN_X) begin
			cam = m_cam - (player_pkg::SCROLL_MIN_X - (screen - (player_pkg::PLAYER_W - 1)));
		end
		if (cam < 0) begin
			cam = 0;
		end else if (cam > player_pkg::CAM_MAX) begin
			cam = player_pkg::CAM_MAX;
		end
		m_x = x_new;
		m_y = y_new;
		m_cam = cam;
		// coins under any corner of the box
		for (i = 0; i < 3; i++) begin
			if ((m_y / TILE == COIN_ROW || (m_y - (player_pkg::PLAYER_H - 1)) / TILE == COIN_ROW)
					&& ((m_x - (player_pkg::PLAYER_W - 1)) / TILE == coin_col[i] ||
					m_x / TILE == coin_col[i])) begin
				m_coins[i] = 1'b0;
			end
		end
	endtask

	// ------------------------------------------------------------
	// drive and check helpers, all entered and left 10 ns after a rising edge
	// ------------------------------------------------------------
	task automatic check_int(input int got, input int exp, input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_player(input string label);
		check_int(int'(player.world_x), m_x, {label, " world_x"});
		check_int(int'(player.y), m_y, {label, " y"});
		check_int(int'(player.cam_x), m_cam, {label, " cam_x"});
		check_int(int'(score), model_score(), {label, " score"});
	endtask

	task automatic apply_reset();
		reset_req = 1'b1;
		wait (Reset);
		wait (!Reset);
		reset_req = 1'b0;
		@(posedge Clk);
		#10;
		model_reset();
	endtask

	task automatic run_frames(input int count, input logic [7:0] key, input string label);
		keycode = key;
		for (int f = 0; f < count; f++) begin
			frame_tick = 1'b1;
			@(posedge Clk);
			#10;
			frame_tick = 1'b0;
			repeat (FRAME_CYCLES - 1) begin
				@(posedge Clk);
				#10;
			end
			model_frame(key);
			compare_player(label);
		end
		keycode = player_pkg::KEY_NONE;
	endtask

	task automatic check_pixel(input int x, input int y, input bit en,
			input level_pkg::rgb_t exp, input string what);
		pixel = '{draw_x: level_pkg::coord_t'(x), draw_y: level_pkg::coord_t'(y), display_en: en};
		@(posedge Clk);
		#10;
		checks++;
		assert (rgb == exp) else begin
			errors++;
			$display("ERR %0t: %s pixel (%0d,%0d) rgb %06h, expected %06h",
				$time, what, x, y, rgb, exp);
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_reset_state();
		model_reset();
		compare_player("reset");
		check_pixel(220, 20, 1'b0, level_pkg::COLOR_BLANK, "blanked");
	endtask

	task automatic test_fall_and_land();
		apply_reset();
		run_frames(60, player_pkg::KEY_NONE, "fall");
		check_int(int'(player.y), 351, "landed y");
		run_frames(8, player_pkg::KEY_NONE, "rest");
		check_int(int'(player.y), 351, "resting y");
	endtask

	task automatic test_walk_right();
		apply_reset();
		run_frames(60, player_pkg::KEY_NONE, "land");
		run_frames(60, player_pkg::KEY_RIGHT, "walk right");
		check_int(int'(player.world_x), 447, "x at block");
		check_int(int'(player.cam_x > 0), 1, "camera scrolled");
	endtask

	task automatic test_coins();
		apply_reset();
		run_frames(60, player_pkg::KEY_NONE, "land");
		run_frames(56, player_pkg::KEY_LEFT, "walk left");
		check_int(int'(score), 2, "score after left walk");
		check_int(int'(player.world_x), 25, "x at left edge");
		run_frames(80, player_pkg::KEY_RIGHT, "walk back");
		check_int(int'(score), 3, "score after right walk");
	endtask

	task automatic test_render_colours();
		apply_reset();
		run_frames(60, player_pkg::KEY_NONE, "land");
		check_pixel(220, 340, 1'b1, level_pkg::COLOR_PLAYER, "player");
		check_pixel(100, 100, 1'b1, level_pkg::COLOR_SKY, "sky");
		check_pixel(100, 400, 1'b1, level_pkg::COLOR_FLOOR, "floor");
		check_pixel(330, 330, 1'b1, level_pkg::COLOR_COIN, "live coin");
		run_frames(60, player_pkg::KEY_RIGHT, "scroll");
		// block at row 9 column 15, seen through the scrolled camera
		check_pixel(490 - m_cam, 300, 1'b1, level_pkg::COLOR_BLOCK, "block");
		check_pixel(330 - m_cam, 330, 1'b1, level_pkg::COLOR_SKY, "collected coin");
	endtask

	// ------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------
	initial begin
		errors = 0;
		checks = 0;
		reset_req = 1'b0;
		frame_tick = 1'b0;
		keycode = player_pkg::KEY_NONE;
		pixel = '{draw_x: '0, draw_y: '0, display_en: 1'b0};
		wait (Reset);
		wait (!Reset);
		@(posedge Clk);
		#10;
		test_reset_state();
		test_fall_and_land();
		test_walk_right();
		test_coins();
		test_render_colours();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished, errors so far: %0d", errors);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== verification/tb_clock.sv ====
// tb_clock: testbench clock and reset source, with a reset on request
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 2
) (
	input  logic reset_req,
	output logic Clk,
	output logic Reset
);

	initial begin
		Clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) Clk = ~Clk;
		end
	end

	// power-on reset, then one more reset for each request
	initial begin
		Reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge Clk);
		#10 Reset = 1'b0;
		forever begin
			@(posedge reset_req);
			Reset = 1'b1;
			repeat (RESET_CYCLES) @(posedge Clk);
			#10 Reset = 1'b0;
		end
	end

endmodule
